//--- Bender.yml
package:
  name: noc_mesh

sources:
  - files:
      - common/noc_flit_pkg.sv
      - common/noc_topo_pkg.sv
      - common/noc_link_if.sv
      - router/noc_in_fifo.sv
      - router/noc_router.sv
      - logic/dummy_tile.sv
      - logic/noc_mesh_top.sv
  - target: test
    files:
      - verif/noc_mesh_checker.sv
      - verif/noc_mesh_tb.sv

//--- common/noc_flit_pkg.sv
// Flit format for the single-channel mesh
// Every packet is one flit, and coordinates use one bit per dimension

package noc_flit_pkg;

  localparam int payload_width = 16;

  // x bit in [1], y bit in [0]
  typedef logic [1:0] coord_t;

  typedef logic [payload_width-1:0] payload_t;

  // Destination sits in the top bits, payload at the bottom
  typedef struct packed {
    coord_t   dst;
    coord_t   src;
    payload_t payload;
  } flit_t;

endpackage

//--- common/noc_link_if.sv
// Valid/ready flit link
// The sender keeps valid and flit stable until the transfer

`timescale 1ns/1ps

interface noc_link_if (
  input logic clk_i
);

  logic                valid;
  logic                ready;
  noc_flit_pkg::flit_t flit;

  modport tx (
    input  clk_i,
    input  ready,
    output valid,
    output flit
  );

  modport rx (
    input  clk_i,
    input  valid,
    input  flit,
    output ready
  );

endinterface

//--- common/noc_topo_pkg.sv
// Mesh geometry and router port numbering
// Only a 2x2 mesh fits the one-bit coordinates
// fifo_depth must be at least 2

package noc_topo_pkg;

  localparam int num_ports     = 5;
  localparam int fifo_depth    = 2;
  localparam int num_endpoints = 2;
  localparam int mesh_dim      = 2;
  localparam int num_nodes     = mesh_dim * mesh_dim;

  // Router port index, mesh neighbors first
  typedef enum logic [2:0] {
    dir_north,
    dir_east,
    dir_south,
    dir_west,
    dir_local
  } dir_e;

  // Dummy tile drop counter, wraps
  typedef logic [7:0] drop_cnt_t;

  ////////////////////////////////////////
  // Node numbering is x + mesh_dim * y
  ////////////////////////////////////////

  function automatic noc_flit_pkg::coord_t node_coord(int node);
    return {1'(node % mesh_dim), 1'(node / mesh_dim)};
  endfunction

  // Diagonal nodes carry endpoints and a local port
  function automatic int node_ports(int node);
    return (node % mesh_dim == node / mesh_dim) ? num_ports : num_ports - 1;
  endfunction

  // Node across a mesh port, -1 at the mesh edge
  function automatic int neighbor(int node, int dir);
    int x;
    int y;
    x = node % mesh_dim;
    y = node / mesh_dim;
    case (dir)
      dir_north: return (y < mesh_dim - 1) ? node + mesh_dim : -1;
      dir_east:  return (x < mesh_dim - 1) ? node + 1 : -1;
      dir_south: return (y > 0) ? node - mesh_dim : -1;
      dir_west:  return (x > 0) ? node - 1 : -1;
      default:   return -1;
    endcase
  endfunction

  function automatic int opposite(int dir);
    return (dir + 2) % (num_ports - 1);
  endfunction

endpackage

//--- logic/dummy_tile.sv
// Router tile without a core
// Never injects, and silently drops every flit addressed to it
// drop_cnt_o counts the dropped flits and wraps

`timescale 1ns/1ps

module dummy_tile #(
  parameter noc_flit_pkg::coord_t tile_xy = '0
) (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  noc_link_if.rx                  in_links  [noc_topo_pkg::num_ports-1],
  noc_link_if.tx                  out_links [noc_topo_pkg::num_ports-1],
  output noc_topo_pkg::drop_cnt_t drop_cnt_o
);

  noc_link_if rt_in  [noc_topo_pkg::num_ports] (.clk_i);
  noc_link_if rt_out [noc_topo_pkg::num_ports] (.clk_i);

  noc_topo_pkg::drop_cnt_t drop_cnt_q;

  noc_router #(
    .router_xy (tile_xy)
  ) i_router (
    .clk_i,
    .rst_n_i,
    .in_links  (rt_in),
    .out_links (rt_out)
  );

  // Mesh ports pass straight to the router
  for (genvar d = 0; d < noc_topo_pkg::num_ports - 1; d++) begin : g_dir
    assign rt_in[d].valid      = in_links[d].valid;
    assign rt_in[d].flit       = in_links[d].flit;
    assign in_links[d].ready   = rt_in[d].ready;
    assign out_links[d].valid  = rt_out[d].valid;
    assign out_links[d].flit   = rt_out[d].flit;
    assign rt_out[d].ready     = out_links[d].ready;
  end

  // Local input stays idle
  assign rt_in[noc_topo_pkg::dir_local].valid = 1'b0;
  assign rt_in[noc_topo_pkg::dir_local].flit  = '0;

  // Local output is a sink
  assign rt_out[noc_topo_pkg::dir_local].ready = 1'b1;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      drop_cnt_q <= '0;
    end else if (rt_out[noc_topo_pkg::dir_local].valid) begin
      drop_cnt_q <= drop_cnt_q + 1'b1;
    end
  end

  assign drop_cnt_o = drop_cnt_q;

endmodule

//--- logic/noc_mesh_top.sv
// 2x2 mesh, routers with endpoints at (0,0) and (1,1), dummy tiles elsewhere
// Endpoint 0 is (0,0), endpoint 1 is (1,1)
// drop_cnt_o[0] is the tile at (1,0), drop_cnt_o[1] the tile at (0,1)

`timescale 1ns/1ps

module noc_mesh_top (
  input  logic                                                    clk_i,
  input  logic                                                    rst_n_i,
  input  logic                 [noc_topo_pkg::num_endpoints-1:0] inj_valid_i,
  output logic                 [noc_topo_pkg::num_endpoints-1:0] inj_ready_o,
  input  noc_flit_pkg::coord_t [noc_topo_pkg::num_endpoints-1:0] inj_dst_i,
  input  noc_flit_pkg::payload_t [noc_topo_pkg::num_endpoints-1:0] inj_payload_i,
  output logic                 [noc_topo_pkg::num_endpoints-1:0] ej_valid_o,
  input  logic                 [noc_topo_pkg::num_endpoints-1:0] ej_ready_i,
  output noc_flit_pkg::coord_t [noc_topo_pkg::num_endpoints-1:0] ej_src_o,
  output noc_flit_pkg::payload_t [noc_topo_pkg::num_endpoints-1:0] ej_payload_o,
  output noc_topo_pkg::drop_cnt_t
         [noc_topo_pkg::num_nodes-noc_topo_pkg::num_endpoints-1:0] drop_cnt_o
);

  for (genvar n = 0; n < noc_topo_pkg::num_nodes; n++) begin : g_node
    noc_link_if rx [noc_topo_pkg::node_ports(n)] (.clk_i);
    noc_link_if tx [noc_topo_pkg::node_ports(n)] (.clk_i);

    ////////////////////////////////////////
    // Mesh links and idle edges
    ////////////////////////////////////////

    for (genvar d = 0; d < noc_topo_pkg::num_ports - 1; d++) begin : g_dir
      if (noc_topo_pkg::neighbor(n, d) >= 0) begin : g_nb
        assign rx[d].valid =
          g_node[noc_topo_pkg::neighbor(n, d)].tx[noc_topo_pkg::opposite(d)].valid;
        assign rx[d].flit =
          g_node[noc_topo_pkg::neighbor(n, d)].tx[noc_topo_pkg::opposite(d)].flit;
        assign tx[d].ready =
          g_node[noc_topo_pkg::neighbor(n, d)].rx[noc_topo_pkg::opposite(d)].ready;
      end else begin : g_edge
        // XY routing never sends off the mesh
        assign rx[d].valid = 1'b0;
        assign rx[d].flit  = '0;
        assign tx[d].ready = 1'b0;
      end
    end

    if (noc_topo_pkg::node_ports(n) == noc_topo_pkg::num_ports) begin : g_router
      noc_router #(
        .router_xy (noc_topo_pkg::node_coord(n))
      ) i_router (
        .clk_i,
        .rst_n_i,
        .in_links  (rx),
        .out_links (tx)
      );

      // Endpoint index is n / 3, source is the node's own position
      assign rx[noc_topo_pkg::dir_local].valid =
        inj_valid_i[n / (noc_topo_pkg::num_nodes - 1)];
      assign rx[noc_topo_pkg::dir_local].flit = '{
        dst:     inj_dst_i[n / (noc_topo_pkg::num_nodes - 1)],
        src:     noc_topo_pkg::node_coord(n),
        payload: inj_payload_i[n / (noc_topo_pkg::num_nodes - 1)]
      };
      assign inj_ready_o[n / (noc_topo_pkg::num_nodes - 1)] =
        rx[noc_topo_pkg::dir_local].ready;

      assign ej_valid_o[n / (noc_topo_pkg::num_nodes - 1)] =
        tx[noc_topo_pkg::dir_local].valid;
      assign ej_src_o[n / (noc_topo_pkg::num_nodes - 1)] =
        tx[noc_topo_pkg::dir_local].flit.src;
      assign ej_payload_o[n / (noc_topo_pkg::num_nodes - 1)] =
        tx[noc_topo_pkg::dir_local].flit.payload;
      assign tx[noc_topo_pkg::dir_local].ready =
        ej_ready_i[n / (noc_topo_pkg::num_nodes - 1)];
    end else begin : g_tile
      // Nodes 1 and 2 map to counters 0 and 1
      dummy_tile #(
        .tile_xy (noc_topo_pkg::node_coord(n))
      ) i_dummy_tile (
        .clk_i,
        .rst_n_i,
        .in_links   (rx),
        .out_links  (tx),
        .drop_cnt_o (drop_cnt_o[n - 1])
      );
    end
  end

endmodule

//--- router/noc_in_fifo.sv
// Input FIFO of one router port
// Ready depends on the fill level only, never on pop_i
// Popping an empty FIFO is ignored

`timescale 1ns/1ps

module noc_in_fifo (
  input  logic                clk_i,
  input  logic                rst_n_i,
  noc_link_if.rx              in_link,
  output noc_flit_pkg::flit_t head_o,
  output logic                head_valid_o,
  input  logic                pop_i
);

  typedef logic [$clog2(noc_topo_pkg::fifo_depth)-1:0]   ptr_t;
  typedef logic [$clog2(noc_topo_pkg::fifo_depth+1)-1:0] cnt_t;

  noc_flit_pkg::flit_t mem_q [noc_topo_pkg::fifo_depth];
  ptr_t                rd_ptr_q;
  ptr_t                wr_ptr_q;
  cnt_t                count_q;
  logic                push;
  logic                pop;

  function automatic ptr_t ptr_inc(ptr_t ptr);
    return (ptr == ptr_t'(noc_topo_pkg::fifo_depth - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign in_link.ready = (count_q != cnt_t'(noc_topo_pkg::fifo_depth));
  assign push          = in_link.valid && in_link.ready;
  assign head_valid_o  = (count_q != '0);
  assign pop           = pop_i && head_valid_o;
  assign head_o        = mem_q[rd_ptr_q];

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= in_link.flit;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      end
      if (pop) begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      end
      count_q <= count_q + cnt_t'(push) - cnt_t'(pop);
    end
  end

endmodule

//--- router/noc_router.sv
// Five-port XY router, input buffered, no output registers
// Output valid never depends on ready, so router chains form no loops
// A stalled grant is held until its transfer

`timescale 1ns/1ps

module noc_router #(
  parameter noc_flit_pkg::coord_t router_xy = '0
) (
  input  logic   clk_i,
  input  logic   rst_n_i,
  noc_link_if.rx in_links  [noc_topo_pkg::num_ports],
  noc_link_if.tx out_links [noc_topo_pkg::num_ports]
);

  noc_flit_pkg::flit_t                head [noc_topo_pkg::num_ports];
  noc_topo_pkg::dir_e                 route [noc_topo_pkg::num_ports];
  noc_topo_pkg::dir_e                 gnt_idx [noc_topo_pkg::num_ports];
  // First input searched by each output arbiter
  noc_topo_pkg::dir_e                 prio_q [noc_topo_pkg::num_ports];
  logic [noc_topo_pkg::num_ports-1:0] head_valid;
  logic [noc_topo_pkg::num_ports-1:0] gnt_valid;
  logic [noc_topo_pkg::num_ports-1:0] out_ready;
  logic [noc_topo_pkg::num_ports-1:0] pop;

  // X first, then Y
  function automatic noc_topo_pkg::dir_e xy_route(noc_flit_pkg::coord_t dst);
    if (dst[1] != router_xy[1]) begin
      return dst[1] ? noc_topo_pkg::dir_east : noc_topo_pkg::dir_west;
    end
    if (dst[0] != router_xy[0]) begin
      return dst[0] ? noc_topo_pkg::dir_north : noc_topo_pkg::dir_south;
    end
    return noc_topo_pkg::dir_local;
  endfunction

  function automatic noc_topo_pkg::dir_e next_dir(noc_topo_pkg::dir_e dir);
    if (dir == noc_topo_pkg::dir_local) begin
      return noc_topo_pkg::dir_north;
    end
    return noc_topo_pkg::dir_e'(dir + 1);
  endfunction

  ////////////////////////////////////////
  // Input ports and output links
  ////////////////////////////////////////

  for (genvar p = 0; p < noc_topo_pkg::num_ports; p++) begin : g_port
    noc_in_fifo i_in_fifo (
      .clk_i,
      .rst_n_i,
      .in_link      (in_links[p]),
      .head_o       (head[p]),
      .head_valid_o (head_valid[p]),
      .pop_i        (pop[p])
    );

    assign route[p]           = xy_route(head[p].dst);
    assign out_ready[p]       = out_links[p].ready;
    assign out_links[p].valid = gnt_valid[p];
    assign out_links[p].flit  = head[gnt_idx[p]];
  end

  ////////////////////////////////////////
  // Round-robin arbitration per output
  ////////////////////////////////////////

  always_comb begin
    int idx;
    gnt_valid = '0;
    for (int o = 0; o < noc_topo_pkg::num_ports; o++) begin
      gnt_idx[o] = prio_q[o];
      for (int k = 0; k < noc_topo_pkg::num_ports; k++) begin
        idx = (int'(prio_q[o]) + k) % noc_topo_pkg::num_ports;
        if (!gnt_valid[o] && head_valid[idx] && int'(route[idx]) == o) begin
          gnt_valid[o] = 1'b1;
          gnt_idx[o]   = noc_topo_pkg::dir_e'(idx);
        end
      end
    end
  end

  // Each input requests one output only, so at most one pop per input
  always_comb begin
    pop = '0;
    for (int o = 0; o < noc_topo_pkg::num_ports; o++) begin
      if (gnt_valid[o] && out_ready[o]) begin
        pop[gnt_idx[o]] = 1'b1;
      end
    end
  end

  // Rotate past the winner after a transfer, stay on it while stalled
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      for (int o = 0; o < noc_topo_pkg::num_ports; o++) begin
        prio_q[o] <= noc_topo_pkg::dir_north;
      end
    end else begin
      for (int o = 0; o < noc_topo_pkg::num_ports; o++) begin
        if (gnt_valid[o]) begin
          prio_q[o] <= out_ready[o] ? next_dir(gnt_idx[o]) : gnt_idx[o];
        end
      end
    end
  end

endmodule

//--- verif/noc_mesh_checker.sv
// Link checks on every router output, bound to each noc_router
// Mesh-edge outputs never go valid and pass trivially

`timescale 1ns/1ps

module noc_mesh_checker (
  input logic                                              clk_i,
  input logic                                              rst_n_i,
  input logic                [noc_topo_pkg::num_ports-1:0] valid_i,
  input logic                [noc_topo_pkg::num_ports-1:0] ready_i,
  input noc_flit_pkg::flit_t [noc_topo_pkg::num_ports-1:0] flit_i
);

  for (genvar p = 0; p < noc_topo_pkg::num_ports; p++) begin : g_port
    // A stalled output keeps its flit until the transfer
    hold_a: assert property (
      @(posedge clk_i) disable iff (!rst_n_i)
      valid_i[p] && !ready_i[p] |=> valid_i[p] && $stable(flit_i[p])
    ) else $error("Output %0d changed while stalled", p);
  end

  // One reset edge clears every FIFO
  reset_a: assert property (
    @(posedge clk_i) !rst_n_i ##1 !rst_n_i |-> valid_i == '0
  ) else $error("Output valid high during reset");

endmodule

bind noc_router noc_mesh_checker i_noc_mesh_checker (
  .clk_i   (clk_i),
  .rst_n_i (rst_n_i),
  .valid_i (gnt_valid),
  .ready_i (out_ready),
  .flit_i  ({out_links[4].flit, out_links[3].flit, out_links[2].flit,
             out_links[1].flit, out_links[0].flit})
);

//--- verif/noc_mesh_tb.sv
// Directed tests for the 2x2 mesh, endpoints at (0,0) and (1,1)
// Inputs change on the rising edge, outputs are sampled on the falling edge
// The run stops at the first mismatch or timeout

`timescale 1ns/1ps

module noc_mesh_tb;

  localparam int timeout_cycles = 400;
  localparam int max_burst      = 16;
  // Long enough for eight flits to fill every buffer on the path
  localparam int fill_cycles    = 12;

  logic                                                          clk_i;
  logic                                                          rst_n_i;
  logic                   [noc_topo_pkg::num_endpoints-1:0]      inj_valid_i;
  logic                   [noc_topo_pkg::num_endpoints-1:0]      inj_ready_o;
  noc_flit_pkg::coord_t   [noc_topo_pkg::num_endpoints-1:0]      inj_dst_i;
  noc_flit_pkg::payload_t [noc_topo_pkg::num_endpoints-1:0]      inj_payload_i;
  logic                   [noc_topo_pkg::num_endpoints-1:0]      ej_valid_o;
  logic                   [noc_topo_pkg::num_endpoints-1:0]      ej_ready_i;
  noc_flit_pkg::coord_t   [noc_topo_pkg::num_endpoints-1:0]      ej_src_o;
  noc_flit_pkg::payload_t [noc_topo_pkg::num_endpoints-1:0]      ej_payload_o;
  noc_topo_pkg::drop_cnt_t [1:0]                                 drop_cnt_o;

  // Scoreboard, indexed by 2 * eject endpoint + source endpoint
  noc_flit_pkg::payload_t  exp_q [4][$];
  int                      sent_cnt [4];
  int                      recv_cnt [4];
  int                      drop_sent [2];
  noc_topo_pkg::drop_cnt_t drop_base [2];
  noc_flit_pkg::payload_t  burst_pay [2][max_burst];
  logic [15:0]             lfsr_q;
  logic                    stall_seen;
  logic                    burst_done;

  noc_mesh_top i_noc_mesh_top (.*);

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////

  // x bit first, then y bit
  function automatic noc_flit_pkg::coord_t xy_coord(int x, int y);
    return noc_flit_pkg::coord_t'({x[0], y[0]});
  endfunction

  function automatic noc_flit_pkg::coord_t ep_coord(int ep);
    return (ep == 0) ? xy_coord(0, 0) : xy_coord(1, 1);
  endfunction

  // -1 for a dummy tile
  function automatic int coord_ep(noc_flit_pkg::coord_t c);
    if (c == xy_coord(0, 0)) begin
      return 0;
    end
    return (c == xy_coord(1, 1)) ? 1 : -1;
  endfunction

  function automatic int coord_tile(noc_flit_pkg::coord_t c);
    return (c == xy_coord(1, 0)) ? 0 : 1;
  endfunction

  // Fibonacci LFSR, x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_bits(int n);
    logic [15:0] bits;
    logic        fb;
    bits = '0;
    for (int i = 0; i < n; i++) begin
      fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
      lfsr_q = {lfsr_q[14:0], fb};
      bits   = {bits[14:0], fb};
    end
    return bits;
  endfunction

  function automatic int queued();
    int total;
    total = 0;
    for (int i = 0; i < 4; i++) begin
      total += exp_q[i].size();
    end
    return total;
  endfunction

  task automatic abort_run(string line);
    $display("%s", line);
    $display("test failed");
    $fatal(1, "Simulation stopped");
  endtask

  task automatic value_error(string msg);
    abort_run($sformatf("[FAIL] %0t: %s", $time, msg));
  endtask

  task automatic fill_burst(int ep, int n);
    for (int i = 0; i < n; i++) begin
      burst_pay[ep][i] = lfsr_bits(noc_flit_pkg::payload_width);
    end
  endtask

  task automatic clear_counts();
    sent_cnt  = '{default: 0};
    recv_cnt  = '{default: 0};
    drop_sent = '{default: 0};
  endtask

  // Send n flits from burst_pay, starting and ending right after a rising edge
  task automatic send_burst(int ep, noc_flit_pkg::coord_t dst, int n);
    int d;
    int waited;
    d = coord_ep(dst);
    for (int i = 0; i < n; i++) begin
      if (d >= 0) begin
        exp_q[2 * d + ep].push_back(burst_pay[ep][i]);
        sent_cnt[2 * d + ep]++;
      end else begin
        drop_sent[coord_tile(dst)]++;
      end
      inj_valid_i[ep]   <= 1'b1;
      inj_dst_i[ep]     <= dst;
      inj_payload_i[ep] <= burst_pay[ep][i];
      waited = 0;
      @(negedge clk_i);
      while (!inj_ready_o[ep]) begin
        stall_seen = 1'b1;
        waited++;
        if (waited > timeout_cycles) begin
          abort_run($sformatf("Timeout waiting for inject ready on endpoint %0d", ep));
        end
        @(negedge clk_i);
      end
      @(posedge clk_i);
    end
    inj_valid_i[ep] <= 1'b0;
  endtask

  task automatic check_eject(int ep, noc_flit_pkg::coord_t src, noc_flit_pkg::payload_t pay);
    int                     s;
    noc_flit_pkg::payload_t exp;
    s = coord_ep(src);
    assert (s >= 0)
      else value_error($sformatf("eject %0d has non-endpoint source %b", ep, src));
    assert (exp_q[2 * ep + s].size() > 0)
      else value_error($sformatf("unexpected flit at eject %0d from %b", ep, src));
    exp = exp_q[2 * ep + s].pop_front();
    assert (pay == exp)
      else value_error($sformatf("eject %0d payload %h, expected %h", ep, pay, exp));
    recv_cnt[2 * ep + s]++;
  endtask

  always @(negedge clk_i) begin
    if (rst_n_i) begin
      for (int e = 0; e < noc_topo_pkg::num_endpoints; e++) begin
        if (ej_valid_o[e] && ej_ready_i[e]) begin
          check_eject(e, ej_src_o[e], ej_payload_o[e]);
        end
      end
    end
  end

  task automatic wait_drained();
    int waited;
    waited = 0;
    while (queued() > 0) begin
      waited++;
      if (waited > timeout_cycles) begin
        abort_run("Timeout waiting for expected flits to arrive");
      end
      @(posedge clk_i);
    end
  endtask

  task automatic check_drops();
    int waited;
    for (int t = 0; t < 2; t++) begin
      waited = 0;
      while (drop_cnt_o[t] != noc_topo_pkg::drop_cnt_t'(drop_base[t] + drop_sent[t])) begin
        waited++;
        if (waited > timeout_cycles) begin
          abort_run($sformatf("Timeout waiting for drop counter %0d", t));
        end
        @(negedge clk_i);
      end
    end
    repeat (4) @(negedge clk_i);
    for (int t = 0; t < 2; t++) begin
      assert (drop_cnt_o[t] == noc_topo_pkg::drop_cnt_t'(drop_base[t] + drop_sent[t]))
        else value_error($sformatf("drop counter %0d is %0d", t, drop_cnt_o[t]));
    end
    @(posedge clk_i);
  endtask

  ////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////

  task automatic crossing();
    fill_burst(0, 1);
    fill_burst(1, 1);
    fork
      send_burst(0, ep_coord(1), 1);
      send_burst(1, ep_coord(0), 1);
    join
    wait_drained();
  endtask

  task automatic loopback();
    fill_burst(0, 2);
    fill_burst(1, 2);
    fork
      send_burst(0, ep_coord(0), 2);
      send_burst(1, ep_coord(1), 2);
    join
    wait_drained();
  endtask

  // Eject ready stays low for a fixed fill time, then follows the LFSR
  task automatic backpressure_order();
    int   waited;
    logic rdy_bit;
    clear_counts();
    fill_burst(0, 8);
    stall_seen = 1'b0;
    burst_done = 1'b0;
    ej_ready_i[1] <= 1'b0;
    fork
      begin
        send_burst(0, ep_coord(1), 8);
        burst_done = 1'b1;
      end
      begin
        waited = 0;
        while (!burst_done || queued() > 0) begin
          @(posedge clk_i);
          rdy_bit = (waited >= fill_cycles) ? lfsr_bits(1) : 1'b0;
          ej_ready_i[1] <= rdy_bit;
          waited++;
          if (waited > timeout_cycles) begin
            abort_run("Timeout waiting for the back-pressured burst");
          end
        end
      end
    join
    ej_ready_i[1] <= 1'b1;
    assert (stall_seen) else value_error("inject ready never dropped");
    assert (recv_cnt[2] == 8)
      else value_error($sformatf("received %0d of 8 flits", recv_cnt[2]));
  endtask

  task automatic dummy_sink();
    clear_counts();
    for (int t = 0; t < 2; t++) begin
      drop_base[t] = drop_cnt_o[t];
    end
    fill_burst(0, 5);
    fill_burst(1, 3);
    send_burst(0, xy_coord(1, 0), 3);
    send_burst(0, xy_coord(0, 1), 2);
    send_burst(1, xy_coord(0, 1), 2);
    send_burst(1, xy_coord(1, 0), 1);
    check_drops();
  endtask

  task automatic contention();
    clear_counts();
    fill_burst(0, 6);
    fill_burst(1, 6);
    fork
      send_burst(0, ep_coord(1), 6);
      send_burst(1, ep_coord(1), 6);
    join
    wait_drained();
    for (int s = 0; s < 2; s++) begin
      assert (recv_cnt[2 + s] == sent_cnt[2 + s])
        else value_error($sformatf("source %0d sent %0d, received %0d",
                                   s, sent_cnt[2 + s], recv_cnt[2 + s]));
    end
  endtask

  initial begin
    rst_n_i       = 1'b0;
    inj_valid_i   = '0;
    inj_dst_i     = '0;
    inj_payload_i = '0;
    ej_ready_i    = '1;
    lfsr_q        = 16'd13;
    stall_seen    = 1'b0;
    burst_done    = 1'b0;
    clear_counts();
    repeat (2) @(posedge clk_i);
    rst_n_i <= 1'b1;
    @(negedge clk_i);
    assert (ej_valid_o == '0) else value_error("eject valid high after reset");
    @(posedge clk_i);
    crossing();
    loopback();
    backpressure_order();
    dummy_sink();
    contention();
    $display("test passed");
    $finish;
  end

endmodule

//--- verilog.f
common/noc_flit_pkg.sv
common/noc_topo_pkg.sv
common/noc_link_if.sv
router/noc_in_fifo.sv
router/noc_router.sv
logic/dummy_tile.sv
logic/noc_mesh_top.sv
verif/noc_mesh_checker.sv
verif/noc_mesh_tb.sv
